// ==== megarom_pkg.sv ====
/*
 * shared widths, mapper mode codes
 * and the bus, bank and RAM request structs
 */
package megarom_pkg;

	// ------------------------------
	// widths with a meaning
	// ------------------------------
	typedef logic [15:0] bus_addr_t;	// CPU address
	typedef logic [7:0]  byte_t;		// one data byte
	typedef logic [7:0]  bank_t;		// 8 KB bank number
	typedef logic [21:0] ram_addr_t;	// byte address in the image RAM

	// mapper kind, a static config input
	typedef logic [2:0] mapper_mode_t;

	localparam mapper_mode_t mode_asc8   = 3'd0;
	localparam mapper_mode_t mode_asc16  = 3'd1;
	localparam mapper_mode_t mode_normal = 3'd2;	// no switching
	localparam mapper_mode_t mode_kon4   = 3'd3;
	localparam mapper_mode_t mode_scc    = 3'd4;
	localparam mapper_mode_t mode_scci   = 3'd5;
	localparam mapper_mode_t mode_gen8   = 3'd6;
	localparam mapper_mode_t mode_gen16  = 3'd7;

	// ------------------------------
	// grouped signals
	// ------------------------------
	typedef struct packed {
		bus_addr_t address;
		byte_t     write_data;
		logic      read;		// one-cycle strobe
		logic      write;		// one-cycle strobe
		logic      memory;		// memory space access
	} bus_req_t;

	typedef struct packed {
		logic      rd;
		logic      wr;
		ram_addr_t address;
		byte_t     wdata;
	} ram_req_t;

	// the four 8 KB page registers
	typedef struct packed {
		bank_t bank0;	// 4000h-5FFFh
		bank_t bank1;	// 6000h-7FFFh
		bank_t bank2;	// 8000h-9FFFh
		bank_t bank3;	// A000h-BFFFh
	} bank_set_t;

endpackage

// ==== megarom_bank_regs.sv ====
/*
 * MegaROM bank-select decode for all mapper kinds,
 * the four bank registers, SCC-I mode register, sound window flag
 */
`timescale 1ns/100ps

module megarom_bank_regs (
	input  logic                     clk,
	input  logic                     n_reset,
	input  megarom_pkg::mapper_mode_t mode,
	input  megarom_pkg::bus_req_t    bus,
	output megarom_pkg::bank_set_t   banks,
	output logic                     scci_ram_en,
	output logic                     sound_hit
);

	megarom_pkg::bank_t bank_q [0:3];	// page registers
	logic [3:0] sel;		// bank write enables for this strobe
	logic       pair;		// 16 KB kinds, write two pages at once
	logic [4:0] a;			// address in 2 KB blocks
	logic [3:0] gen8_sel;	// Generic8 windows, reused by Generic16
	logic       wr_stb;
	logic       scci_en;	// SCC-I (SCC+) register layout
	logic       scci_reg;	// BFFEh/BFFFh mode register
	logic       scc_win;
	logic       scci_win;

	assign a      = bus.address[15:11];
	assign wr_stb = bus.memory && bus.write;

	// generic: 4000h/5000h, 6000h/7000h, 8000h/9000h, A000h/B000h, first 2 KB only
	assign gen8_sel[0] = (a[4:2] == 3'b010) && !a[0];
	assign gen8_sel[1] = (a[4:2] == 3'b011) && !a[0];
	assign gen8_sel[2] = (a[4:2] == 3'b100) && !a[0];
	assign gen8_sel[3] = (a[4:2] == 3'b101) && !a[0];

	// ------------------------------
	// write window decode per mode
	// ------------------------------
	always_comb begin
		sel  = 4'b0000;
		pair = 1'b0;
		case (mode)
			megarom_pkg::mode_asc8: begin
				sel[0] = (a == 5'b01100);	// 6000h-67FFh
				sel[1] = (a == 5'b01101);	// 6800h-6FFFh
				sel[2] = (a == 5'b01110);	// 7000h-77FFh
				sel[3] = (a == 5'b01111);	// 7800h-7FFFh
			end
			megarom_pkg::mode_asc16: begin
				pair     = 1'b1;
				sel[1:0] = {2{a == 5'b01100}};	// 6000h-67FFh, lower 16 KB
				sel[3:2] = {2{a == 5'b01110}};	// 7000h-77FFh, upper 16 KB
			end
			megarom_pkg::mode_kon4: begin
				// bank0 stays on page 0
				sel[1] = (a[4:2] == 3'b011);	// 6000h-7FFFh
				sel[2] = (a[4:2] == 3'b100);	// 8000h-9FFFh
				sel[3] = (a[4:2] == 3'b101);	// A000h-BFFFh
			end
			megarom_pkg::mode_scc, megarom_pkg::mode_scci: begin
				sel[0] = (a == 5'b01010);	// 5000h-57FFh
				sel[1] = (a == 5'b01110);	// 7000h-77FFh
				sel[2] = (a == 5'b10010);	// 9000h-97FFh
				sel[3] = (a == 5'b10110);	// B000h-B7FFh
			end
			megarom_pkg::mode_gen8: begin
				sel = gen8_sel;
			end
			megarom_pkg::mode_gen16: begin
				pair     = 1'b1;
				sel[1:0] = {2{gen8_sel[0] | gen8_sel[1]}};
				sel[3:2] = {2{gen8_sel[2] | gen8_sel[3]}};
			end
			default: begin
				// plain ROM, pages fixed at 0..3
			end
		endcase
	end

	// ------------------------------
	// bank registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int i = 0; i < 4; i++) begin
				bank_q[i] <= megarom_pkg::bank_t'(i);	// identity mapping
			end
		end else if (wr_stb) begin
			for (int i = 0; i < 4; i++) begin
				if (sel[i]) begin
					// pair: even page first, odd page second
					bank_q[i] <= pair ? {bus.write_data[6:0], i[0]} : bus.write_data;
				end
			end
		end
	end

	assign banks.bank0 = bank_q[0];
	assign banks.bank1 = bank_q[1];
	assign banks.bank2 = bank_q[2];
	assign banks.bank3 = bank_q[3];

	// SCC-I mode register at BFFEh/BFFFh
	assign scci_reg = (mode == megarom_pkg::mode_scci) && (bus.address[15:1] == 15'h5fff);

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			scci_en     <= 1'b0;
			scci_ram_en <= 1'b0;
		end else if (wr_stb && scci_reg) begin
			scci_en     <= bus.write_data[5];
			scci_ram_en <= bus.write_data[4];	// pages become writable RAM
		end
	end

	// ------------------------------
	// sound register windows
	// ------------------------------
	// SCC layout 9800h-9FFFh, selected by page 3Fh in bank2
	assign scc_win = ((mode == megarom_pkg::mode_scc) ||
		((mode == megarom_pkg::mode_scci) && !scci_en)) &&
		(a == 5'b10011) && (bank_q[2] == 8'h3f);

	// SCC+ layout B800h-BFFFh, selected by bank3 bit 7
	assign scci_win = (mode == megarom_pkg::mode_scci) && scci_en &&
		(a == 5'b10111) && bank_q[3][7];

	assign sound_hit = scc_win || scci_win || scci_reg;

	// plain ROM never remaps
	a_normal_fixed: assert property (@(posedge clk) disable iff (!n_reset)
		(mode == megarom_pkg::mode_normal) |=> $stable(banks));

endmodule

// ==== ip_megarom.sv ====
/*
 * MegaROM slot logic, bus strobes to banked RAM requests
 */
`timescale 1ns/100ps

module ip_megarom #(
	parameter logic address_h = 1'b0	// top RAM address bit
) (
	input  logic                      clk,
	input  logic                      n_reset,
	input  megarom_pkg::mapper_mode_t mode,
	input  megarom_pkg::bus_req_t     bus,
	output logic                      bus_memory_cs,
	output logic                      bus_read_ready,
	output megarom_pkg::byte_t        bus_read_data,
	output megarom_pkg::ram_req_t     ram_req,
	input  logic                      busy,
	input  megarom_pkg::byte_t        rdata,
	input  logic                      rdata_en
);

	megarom_pkg::bank_set_t banks;
	megarom_pkg::bank_t     bank;	// page for the current address
	logic scci_ram_en;
	logic sound_hit;
	logic claim;		// 4000h-BFFFh minus sound windows
	logic sel_win;		// SCC bank-select window, xx10_1xxxh
	logic hold;			// request waiting on the RAM side

	megarom_bank_regs u_bank_regs (
		.clk         (clk),
		.n_reset     (n_reset),
		.mode        (mode),
		.bus         (bus),
		.banks       (banks),
		.scci_ram_en (scci_ram_en),
		.sound_hit   (sound_hit)
	);

	assign claim         = (bus.address[15:14] == 2'b01 || bus.address[15:14] == 2'b10) &&
		!sound_hit;
	assign bus_memory_cs = bus.memory && claim;

	// 5000h/7000h/9000h/B000h first 2 KB, the only select windows in SCC-I mode
	assign sel_win = (bus.address[12:11] == 2'b10);

	// ------------------------------
	// page lookup, A14:A13
	// ------------------------------
	always_comb begin
		case (bus.address[14:13])
			2'b10:   bank = banks.bank0;	// 4000h
			2'b11:   bank = banks.bank1;	// 6000h
			2'b00:   bank = banks.bank2;	// 8000h
			default: bank = banks.bank3;	// A000h
		endcase
	end

	assign hold = (ram_req.rd || ram_req.wr) && busy;

	// request strobes
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ram_req.rd <= 1'b0;
			ram_req.wr <= 1'b0;
		end else if (!hold) begin
			ram_req.rd <= bus_memory_cs && bus.read;
			ram_req.wr <= bus_memory_cs && bus.write && scci_ram_en && !sel_win;
		end
	end

	// request payload
	always_ff @(posedge clk) begin
		if (!hold) begin
			ram_req.address <= {address_h, bank, bus.address[12:0]};
			ram_req.wdata   <= bus.write_data;
		end
	end

	assign bus_read_ready = rdata_en;	// straight from RAM side
	assign bus_read_data  = rdata;

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!n_reset)
		!(ram_req.rd && ram_req.wr));

endmodule

// ==== ram_ctrl.sv ====
/*
 * byte RAM controller, mapper and loader requests,
 * fixed read latency
 */
`timescale 1ns/100ps

module ram_ctrl #(
	parameter int read_latency     = 3,		// 2 or more
	parameter int ram_address_bits = 22
) (
	input  logic                  clk,
	input  logic                  n_reset,
	input  megarom_pkg::ram_req_t ram_req,
	output logic                  busy,
	output megarom_pkg::byte_t    rdata,
	output logic                  rdata_en,
	input  logic                  load_wr,
	input  megarom_pkg::ram_addr_t load_address,
	input  megarom_pkg::byte_t    load_data,
	output logic                  load_busy
);

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_write
	} state_t;

	localparam int cnt_w = $clog2(read_latency + 1);
	typedef logic [cnt_w-1:0] cnt_t;

	megarom_pkg::byte_t mem [0:(2**ram_address_bits)-1];	// ROM image

	state_t                     state;
	cnt_t                       cnt;		// read cycles left
	logic                       load_pend;	// loader write waiting
	megarom_pkg::ram_addr_t     load_addr_q;
	megarom_pkg::byte_t         load_data_q;
	logic [ram_address_bits-1:0] addr_q;	// address of the access in flight
	megarom_pkg::byte_t         wdata_q;
	logic                       map_req;
	logic                       take_map;
	logic                       take_load;

	assign map_req   = ram_req.rd || ram_req.wr;
	assign take_map  = (state == st_idle) && map_req;
	assign take_load = (state == st_idle) && !map_req && load_pend;	// only on a free edge

	assign busy      = (state != st_idle);
	assign load_busy = load_pend;

	// ------------------------------
	// control FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state     <= st_idle;
			cnt       <= '0;
			load_pend <= 1'b0;
			rdata_en  <= 1'b0;
		end else begin
			rdata_en <= 1'b0;	// one-cycle pulse
			if (load_wr) begin
				load_pend <= 1'b1;
			end else if (take_load) begin
				load_pend <= 1'b0;
			end
			case (state)
				st_idle: begin
					if (ram_req.rd) begin
						state <= st_read;
						cnt   <= cnt_t'(read_latency - 2);
					end else if (ram_req.wr || load_pend) begin
						state <= st_write;
					end
				end
				st_read: begin
					if (cnt == '0) begin
						state    <= st_idle;
						rdata_en <= 1'b1;	// data lands with it
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				st_write: state <= st_idle;	// single cycle
				default:  state <= st_idle;
			endcase
		end
	end

	// ------------------------------
	// payload and array
	// ------------------------------
	always_ff @(posedge clk) begin
		if (load_wr) begin
			load_addr_q <= load_address;
			load_data_q <= load_data;
		end
		if (take_map) begin
			addr_q  <= ram_req.address[ram_address_bits-1:0];
			wdata_q <= ram_req.wdata;
		end else if (take_load) begin
			addr_q  <= load_addr_q[ram_address_bits-1:0];
			wdata_q <= load_data_q;
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_write) begin
			mem[addr_q] <= wdata_q;
		end
		if (state == st_read && cnt == '0) begin
			rdata <= mem[addr_q];
		end
	end

	// ready leaves st_read, read_latency cycles after the request sat in st_idle
	a_rdata_from_read: assert property (@(posedge clk) disable iff (!n_reset)
		rdata_en |-> ($past(state) == st_read &&
			$past(state, read_latency) == st_idle));

	// a request that meets busy must wait unchanged until st_idle takes it
	a_no_accept_busy: assert property (@(posedge clk) disable iff (!n_reset)
		(busy && map_req) |=> (map_req && $stable(ram_req)));

endmodule

// ==== ip_cartridge_top.sv ====
/*
 * cartridge top, MegaROM mapper plus image RAM controller
 */
`timescale 1ns/100ps

module ip_cartridge_top #(
	parameter logic slot_address_h = 1'b0,	// upper or lower 2 MB of RAM
	parameter int   read_latency   = 3
) (
	input  logic                       clk,
	input  logic                       n_reset,
	// MSX bus
	input  megarom_pkg::bus_req_t      bus,
	output logic                       bus_memory_cs,
	output logic                       bus_read_ready,
	output megarom_pkg::byte_t         bus_read_data,
	// image loader
	input  logic                       load_wr,
	input  megarom_pkg::ram_addr_t     load_address,
	input  megarom_pkg::byte_t         load_data,
	output logic                       load_busy,
	input  megarom_pkg::mapper_mode_t  mode	// static while the bus runs
);

	megarom_pkg::ram_req_t ram_req;
	megarom_pkg::byte_t    rdata;
	logic                  busy;
	logic                  rdata_en;

	ip_megarom #(
		.address_h (slot_address_h)
	) u_megarom (
		.clk            (clk),
		.n_reset        (n_reset),
		.mode           (mode),
		.bus            (bus),
		.bus_memory_cs  (bus_memory_cs),
		.bus_read_ready (bus_read_ready),
		.bus_read_data  (bus_read_data),
		.ram_req        (ram_req),
		.busy           (busy),
		.rdata          (rdata),
		.rdata_en       (rdata_en)
	);

	ram_ctrl #(
		.read_latency     (read_latency),
		.ram_address_bits (22)
	) u_ram_ctrl (
		.clk          (clk),
		.n_reset      (n_reset),
		.ram_req      (ram_req),
		.busy         (busy),
		.rdata        (rdata),
		.rdata_en     (rdata_en),
		.load_wr      (load_wr),
		.load_address (load_address),
		.load_data    (load_data),
		.load_busy    (load_busy)
	);

endmodule

// ==== tb_cartridge_tasks.svh ====
/*
 * testbench helpers: LFSR stimulus, reference address and claim
 * functions, typed compare tasks
 */
`ifndef TB_CARTRIDGE_TASKS_SVH
`define TB_CARTRIDGE_TASKS_SVH

// ------------------------------
// stimulus
// ------------------------------
// x^16 + x^14 + x^13 + x^11 + 1, right-shift Galois form
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

// one LFSR step per bit taken
task automatic rand_bits(input int n, output logic [15:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		v      = {v[14:0], lfsr_q[0]};
		lfsr_q = lfsr_next(lfsr_q);
	end
endtask

// ------------------------------
// reference model
// ------------------------------
// 4000h..A000h pages map to 0..3 via {A15, A13}
function automatic megarom_pkg::ram_addr_t ref_address(input megarom_pkg::mapper_mode_t m,
		input megarom_pkg::bus_addr_t a);
	logic [1:0]         p;
	megarom_pkg::bank_t b;
	p = {a[15], a[13]};
	if (m == megarom_pkg::mode_normal) begin
		b = {6'b000000, p};	// plain ROM, identity pages
	end else begin
		b = model_bank[p];
	end
	return {slot_h, b, a[12:0]};
endfunction

// 4000h-BFFFh less any sound register window
function automatic logic ref_claim(input megarom_pkg::mapper_mode_t m,
		input megarom_pkg::bus_addr_t a);
	logic in_win;
	logic snd;
	in_win = (a[15:14] == 2'b01) || (a[15:14] == 2'b10);
	snd    = 1'b0;
	if (m == megarom_pkg::mode_scc || (m == megarom_pkg::mode_scci && !model_scci_en)) begin
		snd = (a[15:11] == 5'b10011) && (model_bank[2] == 8'h3f);	// 9800h window
	end
	if (m == megarom_pkg::mode_scci && model_scci_en && a[15:11] == 5'b10111 && model_bank[3][7]) begin
		snd = 1'b1;	// B800h window, SCC+ layout
	end
	if (m == megarom_pkg::mode_scci && a[15:1] == 15'h5fff) begin
		snd = 1'b1;	// mode register
	end
	return in_win && !snd;
endfunction

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_byte(input string name, input megarom_pkg::byte_t got,
		input megarom_pkg::byte_t exp);
	chk_count++;
	if (got !== exp) begin
		$display("** Error: %s = %h, expected %h", name, got, exp);
		err_count++;
	end
endtask

task automatic check_cs(input string name, input logic got, input logic exp);
	chk_count++;
	if (got !== exp) begin
		$display("** Error: %s = %h, expected %h", name, got, exp);
		err_count++;
	end
endtask

`endif

// ==== tb_cartridge.sv ====
/*
 * testbench for the MegaROM cartridge, image load, mapper
 * mode tests, read comparator and closing report
 */
`timescale 1ns/100ps

module tb_cartridge;

	localparam logic slot_h        = 1'b0;
	localparam int   read_latency  = 3;
	localparam int   ready_timeout = 50;	// cycles
	localparam int   load_timeout  = 20;

	logic                      clk;
	logic                      n_reset;
	megarom_pkg::bus_req_t     bus;
	logic                      bus_memory_cs;
	logic                      bus_read_ready;
	megarom_pkg::byte_t        bus_read_data;
	logic                      load_wr;
	megarom_pkg::ram_addr_t    load_address;
	megarom_pkg::byte_t        load_data;
	logic                      load_busy;
	megarom_pkg::mapper_mode_t mode;

	// model state
	megarom_pkg::bank_t        model_bank [0:3];
	logic                      model_ram_en;
	logic                      model_scci_en;
	megarom_pkg::mapper_mode_t cur_mode;
	megarom_pkg::byte_t        image [megarom_pkg::ram_addr_t];	// image copy
	megarom_pkg::byte_t        exp_q [$];		// expected read bytes in order
	logic [15:0]               lfsr_q = 16'd75;
	int                        err_count = 0;
	int                        chk_count = 0;
	int                        err_mark;
	int                        chk_mark;

	`include "tb_cartridge_tasks.svh"

	ip_cartridge_top #(
		.slot_address_h (slot_h),
		.read_latency   (read_latency)
	) UUT (
		.clk            (clk),
		.n_reset        (n_reset),
		.bus            (bus),
		.bus_memory_cs  (bus_memory_cs),
		.bus_read_ready (bus_read_ready),
		.bus_read_data  (bus_read_data),
		.load_wr        (load_wr),
		.load_address   (load_address),
		.load_data      (load_data),
		.load_busy      (load_busy),
		.mode           (mode)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns
	end

	// read data comparator
	always @(negedge clk) begin
		if (n_reset && bus_read_ready) begin
			if (exp_q.size() == 0) begin
				$display("unexpected read ready from the DUT with no claimed read pending");
				err_count++;
			end else begin
				check_byte("bus_read_data", bus_read_data, exp_q.pop_front());
			end
		end
	end

	// ------------------------------
	// bus and loader tasks
	// ------------------------------
	function automatic megarom_pkg::bus_addr_t page_addr(input logic [1:0] p,
			input logic [12:0] off);
		return {p[1], ~p[1], p[0], off};	// page 0..3 -> 4000h..A000h
	endfunction

	task automatic apply_reset(input megarom_pkg::mapper_mode_t m);
		@(posedge clk);
		n_reset <= 1'b0;
		mode    <= m;	// changed only under reset
		bus     <= '0;
		load_wr <= 1'b0;
		repeat (16) @(posedge clk);
		n_reset <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			model_bank[i] = megarom_pkg::bank_t'(i);
		end
		model_ram_en  = 1'b0;
		model_scci_en = 1'b0;
		cur_mode      = m;
	endtask

	task automatic load_byte(input megarom_pkg::ram_addr_t a, input megarom_pkg::byte_t d);
		logic done;
		@(posedge clk);
		load_wr      <= 1'b1;
		load_address <= a;
		load_data    <= d;
		@(posedge clk);
		load_wr <= 1'b0;
		done = 1'b0;
		for (int i = 0; i < load_timeout && !done; i++) begin
			@(negedge clk);
			done = (i > 0) && !load_busy;	// busy rises one cycle after the strobe
		end
		if (!done) begin
			$display("timeout: loader still busy after %0d cycles, RAM address %h", load_timeout, a);
			err_count++;
		end
	endtask

	// mapper rules, applied to the model on every bus write
	task automatic model_write(input megarom_pkg::bus_addr_t a, input megarom_pkg::byte_t d);
		logic [1:0] p;
		logic       in_win;
		p      = {a[15], a[13]};
		in_win = (a[15:14] == 2'b01) || (a[15:14] == 2'b10);
		// RAM write sees the banks before this strobe
		if (cur_mode == megarom_pkg::mode_scci && model_ram_en && ref_claim(cur_mode, a) &&
				a[12:11] != 2'b10) begin
			image[ref_address(cur_mode, a)] = d;
		end
		case (cur_mode)
			megarom_pkg::mode_asc8: if (a[15:13] == 3'b011) model_bank[a[12:11]] = d;
			megarom_pkg::mode_asc16: begin
				if (a[15:13] == 3'b011 && !a[11]) begin	// 6000h or 7000h
					model_bank[{a[12], 1'b0}] = {d[6:0], 1'b0};
					model_bank[{a[12], 1'b1}] = {d[6:0], 1'b1};
				end
			end
			megarom_pkg::mode_kon4: if (in_win && p != 2'd0) model_bank[p] = d;
			megarom_pkg::mode_scc,
			megarom_pkg::mode_scci: if (in_win && a[12:11] == 2'b10) model_bank[p] = d;
			megarom_pkg::mode_gen8: if (in_win && !a[11]) model_bank[p] = d;
			megarom_pkg::mode_gen16: begin
				if (in_win && !a[11]) begin
					model_bank[{p[1], 1'b0}] = {d[6:0], 1'b0};
					model_bank[{p[1], 1'b1}] = {d[6:0], 1'b1};
				end
			end
			default: ;	// plain ROM
		endcase
		if (cur_mode == megarom_pkg::mode_scci && a[15:1] == 15'h5fff) begin
			model_scci_en = d[5];
			model_ram_en  = d[4];
		end
	endtask

	task automatic bus_write(input megarom_pkg::bus_addr_t a, input megarom_pkg::byte_t d);
		@(posedge clk);
		bus.address    <= a;
		bus.write_data <= d;
		bus.write      <= 1'b1;
		bus.memory     <= 1'b1;
		@(posedge clk);
		bus.write  <= 1'b0;
		bus.memory <= 1'b0;
		@(posedge clk);	// 2 cycles before the next strobe
		model_write(a, d);
	endtask

	task automatic bus_read(input megarom_pkg::bus_addr_t a, output logic cs, output logic rdy);
		@(posedge clk);
		bus.address <= a;
		bus.read    <= 1'b1;
		bus.memory  <= 1'b1;
		@(negedge clk);
		cs = bus_memory_cs;	// strobe cycle
		@(posedge clk);
		bus.read   <= 1'b0;
		bus.memory <= 1'b0;
		rdy = 1'b0;
		for (int i = 0; i < ready_timeout && !rdy; i++) begin
			@(negedge clk);
			rdy = bus_read_ready;
		end
	endtask

	task automatic read_check(input megarom_pkg::bus_addr_t a);
		megarom_pkg::ram_addr_t ra;
		logic                   exp_cs;
		logic                   cs;
		logic                   rdy;
		exp_cs = ref_claim(cur_mode, a);
		ra     = ref_address(cur_mode, a);
		if (exp_cs && !image.exists(ra)) begin
			$display("no image byte modeled at RAM address %h, read of %h skipped", ra, a);
			err_count++;
		end else begin
			if (exp_cs) begin
				exp_q.push_back(image[ra]);
			end
			bus_read(a, cs, rdy);
			check_cs("bus_memory_cs", cs, exp_cs);
			if (exp_cs && !rdy) begin
				$display("timeout: no read ready within %0d cycles, address %h", ready_timeout, a);
				err_count++;
				exp_q.delete();
			end
		end
	endtask

	task automatic test_start();
		err_mark = err_count;
		chk_mark = chk_count;
	endtask

	task automatic test_done(input string name);
		$display("test %-24s %0d checks, %0d errors", name, chk_count - chk_mark,
			err_count - err_mark);
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		logic [15:0]            r;
		logic [15:0]            v;
		logic [15:0]            o;
		megarom_pkg::ram_addr_t ra;
		megarom_pkg::bus_addr_t a;
		n_reset      = 1'b0;
		bus          = '0;
		load_wr      = 1'b0;
		load_address = '0;
		load_data    = '0;
		mode         = megarom_pkg::mode_normal;
		cur_mode     = megarom_pkg::mode_normal;
		apply_reset(megarom_pkg::mode_normal);

		// 64 KB image, banks 0..7
		for (int i = 0; i < 65536; i++) begin
			rand_bits(8, r);
			image[megarom_pkg::ram_addr_t'(i)] = r[7:0];
			load_byte(megarom_pkg::ram_addr_t'(i), r[7:0]);
		end
		image[22'h07e000] = 8'h5a;	// page 3Fh marker for the SCC test
		load_byte(22'h07e000, 8'h5a);

		test_start();
		for (int m = 0; m < 8; m++) begin
			apply_reset(megarom_pkg::mapper_mode_t'(m));
			for (int p = 0; p < 4; p++) read_check(page_addr(2'(p), 13'h0000));
			read_check(16'h0000);	// outside the slot pages
			read_check(16'hc000);
		end
		test_done("reset mapping");

		test_start();
		for (int k = 0; k < 2; k++) begin
			apply_reset(k == 0 ? megarom_pkg::mode_asc8 : megarom_pkg::mode_gen8);
			repeat (6) begin
				rand_bits(2, r);
				rand_bits(3, v);	// banks 0..7 stay in the image
				a = (k == 0) ? {3'b011, r[1:0], 11'h000} : page_addr(r[1:0], 13'h0000);
				bus_write(a, {5'b00000, v[2:0]});
				repeat (4) begin
					rand_bits(2, r);
					rand_bits(13, o);
					read_check(page_addr(r[1:0], o[12:0]));
				end
			end
		end
		test_done("asc8/generic8 random");

		test_start();
		for (int k = 0; k < 2; k++) begin
			apply_reset(k == 0 ? megarom_pkg::mode_asc16 : megarom_pkg::mode_gen16);
			repeat (4) begin
				rand_bits(1, r);
				rand_bits(2, v);
				// ASC16 6000h/7000h, Generic16 4000h/8000h
				a = (k == 0) ? {3'b011, r[0], 12'h000} : page_addr({r[0], 1'b0}, 13'h0000);
				bus_write(a, {6'b000000, v[1:0]});
				rand_bits(13, o);
				read_check(page_addr({r[0], 1'b0}, o[12:0]));
				read_check(page_addr({r[0], 1'b1}, o[12:0]));
			end
		end
		test_done("asc16/generic16 pairs");

		test_start();
		for (int k = 0; k < 2; k++) begin
			apply_reset(k == 0 ? megarom_pkg::mode_kon4 : megarom_pkg::mode_normal);
			for (int p = 0; p < 4; p++) begin
				rand_bits(3, v);
				bus_write(page_addr(2'(p), 13'h0000), {5'b00000, v[2:0]});	// 4000h ignored
			end
			for (int p = 0; p < 4; p++) begin
				rand_bits(13, o);
				read_check(page_addr(2'(p), o[12:0]));
			end
		end
		test_done("konami4/normal");

		test_start();
		apply_reset(megarom_pkg::mode_scc);
		bus_write(16'h9000, 8'h3f);	// opens the sound window
		read_check(16'h9800);
		read_check(16'h9c55);
		read_check(16'h8000);	// still served, marker byte
		read_check(16'ha123);
		test_done("scc window");

		test_start();
		apply_reset(megarom_pkg::mode_scci);
		read_check(16'hbffe);	// mode register, not claimed
		bus_write(16'hbffe, 8'h10);	// RAM write enable
		ra = ref_address(cur_mode, 16'h6100);
		bus_write(16'h6100, image[ra] ^ 8'hff);
		read_check(16'h6100);
		bus_write(16'hbffe, 8'h00);
		ra = ref_address(cur_mode, 16'h6200);
		bus_write(16'h6200, image[ra] ^ 8'h0f);	// should be dropped
		read_check(16'h6200);
		read_check(16'h6100);
		test_done("scc-i ram write");

		$display("checks %0d, errors %0d", chk_count, err_count);
		if (err_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
megarom_pkg.sv
megarom_bank_regs.sv
ip_megarom.sv
ram_ctrl.sv
ip_cartridge_top.sv
tb_cartridge.sv

// ==== Makefile ====
# Verilator build and run for the MegaROM cartridge testbench

VERILATOR ?= verilator
TOP       ?= tb_cartridge
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) tb_cartridge_tasks.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) $(SIM_ARGS) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "FAIL: run incomplete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
